// File: design/trs_io_pkg.sv
package trs_io_pkg;

  // one byte on spi or on the z80 data bus
  typedef logic [7:0] byte_t;

  // full z80 address
  typedef logic [15:0] trs_addr_t;

  // esp command opcodes still served by the bridge
  typedef enum logic [7:0] {
    CMD_GET_COOKIE  = 8'd0,   // identity probe
    CMD_BRAM_POKE   = 8'd1,   // addr lo, addr hi, data
    CMD_BRAM_PEEK   = 8'd2,   // addr lo, addr hi then one reply
    CMD_GET_VERSION = 8'd15,  // major in [7:5], minor in [4:0]
    CMD_SET_LED     = 8'd26   // bits 2..0 are blue, green, red
  } cmd_e;

  // answer to get_cookie
  localparam byte_t COOKIE = 8'haf;

  // firmware revision reported to the esp
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

endpackage

// File: design/mem_req_if.sv
`timescale 1ns/1ps

// one requester's four-phase handshake into the shared ram
interface mem_req_if #(
  parameter int MEM_ADDR_W = 15
);
  logic                    req;    // held until ack
  logic [MEM_ADDR_W-1:0]   addr;   // stable while req
  logic                    we;     // 1 = write
  trs_io_pkg::byte_t       wdata;
  logic                    ack;    // high until req drops
  trs_io_pkg::byte_t       rdata;  // valid while ack

  modport requester (
    output req, addr, we, wdata,
    input  ack, rdata
  );

  modport arbiter (
    input  req, addr, we, wdata,
    output ack, rdata
  );
endinterface

// File: design/spi_slave.sv
`timescale 1ns/1ps

module spi_slave (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  logic              spi_cs_n,
  input  logic              spi_sck,
  input  logic              spi_mosi,
  input  trs_io_pkg::byte_t tx_byte,
  input  logic              tx_load,
  output logic              spi_miso,
  output trs_io_pkg::byte_t rx_byte,
  output logic              rx_valid,
  output logic              frame_active
);

  logic [2:0]        sck_sync;   // 3 flop chains from the esp pins
  logic [2:0]        cs_sync;
  logic [2:0]        mosi_sync;
  logic [2:0]        bit_cnt;    // wraps to 0 after bit 8
  logic              sck_rise;
  logic              sck_fall;
  trs_io_pkg::byte_t rx_shift;
  trs_io_pkg::byte_t tx_shift;   // msb is on miso

  assign sck_rise     = (sck_sync[2:1] == 2'b01);
  assign sck_fall     = (sck_sync[2:1] == 2'b10);
  assign frame_active = ~cs_sync[2];
  assign spi_miso     = tx_shift[7];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 3'b111;      // deselected
      mosi_sync <= 3'b000;
      bit_cnt   <= 3'd0;
      rx_valid  <= 1'b0;
      tx_shift  <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], spi_sck};
      cs_sync   <= {cs_sync[1:0], spi_cs_n};
      mosi_sync <= {mosi_sync[1:0], spi_mosi};
      rx_valid  <= 1'b0;
      if (!frame_active) begin
        bit_cnt  <= 3'd0;         // resync on cs
        tx_shift <= '0;           // drop a stale reply
      end else begin
        if (sck_rise) begin
          bit_cnt  <= bit_cnt + 3'd1;
          rx_valid <= (bit_cnt == 3'd7);  // eighth bit
        end
        if (tx_load)
          tx_shift <= tx_byte;    // msb shows before first sck rise
        else if (sck_fall && bit_cnt != 3'd0)
          tx_shift <= {tx_shift[6:0], 1'b0};  // no shift on trailing fall
      end
    end
  end

  // mode 0 sampling, msb first
  always_ff @(posedge clk) begin
    if (frame_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_sync[2]};
      if (bit_cnt == 3'd7)
        rx_byte <= {rx_shift[6:0], mosi_sync[2]};
    end
  end

endmodule

// File: design/cmd_engine.sv
`timescale 1ns/1ps

module cmd_engine #(
  parameter int MEM_ADDR_W = 15
) (
  input  logic              clk,
  input  logic              cass_out_sel_n,
  input  trs_io_pkg::byte_t rx_byte,
  input  logic              rx_valid,
  input  logic              frame_active,
  output trs_io_pkg::byte_t tx_byte,
  output logic              tx_load,
  output logic              led_red,
  output logic              led_green,
  output logic              led_blue,
  output logic              spi_error,
  mem_req_if.requester      mem
);

  typedef enum logic [1:0] {idle, read_params, mem_wait, respond} state_e;

  state_e            state;
  trs_io_pkg::cmd_e  cmd;           // opcode being served
  trs_io_pkg::byte_t params [0:2];
  logic [1:0]        bytes_left;    // params still expected
  logic [1:0]        idx;           // next param slot
  logic              mem_go;        // fire the ram request
  logic [15:0]       param_addr;

  assign param_addr = {params[1], params[0]};  // hi, lo

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state      <= idle;
      cmd        <= trs_io_pkg::CMD_GET_COOKIE;
      bytes_left <= 2'd0;
      idx        <= 2'd0;
      mem_go     <= 1'b0;
      mem.req    <= 1'b0;
      tx_byte    <= '0;
      tx_load    <= 1'b0;
      led_red    <= 1'b0;
      led_green  <= 1'b0;
      led_blue   <= 1'b0;
      spi_error  <= 1'b0;
    end else begin
      tx_load <= 1'b0;
      mem_go  <= 1'b0;
      if (mem_go)
        mem.req <= 1'b1;
      else if (mem.ack)
        mem.req <= 1'b0;          // finishes even if cs went away
      if (!frame_active) begin
        state <= idle;
      end else begin
        case (state)
          idle: if (rx_valid) begin
            cmd <= trs_io_pkg::cmd_e'(rx_byte);
            idx <= 2'd0;
            case (rx_byte)
              trs_io_pkg::CMD_GET_COOKIE: begin
                tx_byte <= trs_io_pkg::COOKIE;
                tx_load <= 1'b1;
                state   <= respond;
              end
              trs_io_pkg::CMD_GET_VERSION: begin
                tx_byte <= {trs_io_pkg::VERSION_MAJOR, trs_io_pkg::VERSION_MINOR};
                tx_load <= 1'b1;
                state   <= respond;
              end
              trs_io_pkg::CMD_BRAM_POKE: begin
                bytes_left <= 2'd3;
                state      <= read_params;
              end
              trs_io_pkg::CMD_BRAM_PEEK: begin
                bytes_left <= 2'd2;
                state      <= read_params;
              end
              trs_io_pkg::CMD_SET_LED: begin
                bytes_left <= 2'd1;
                state      <= read_params;
              end
              default: spi_error <= 1'b1;  // sticky until reset
            endcase
          end
          read_params: if (rx_valid) begin
            idx        <= idx + 2'd1;
            bytes_left <= bytes_left - 2'd1;
            if (bytes_left == 2'd1) begin
              if (cmd == trs_io_pkg::CMD_SET_LED) begin
                led_red   <= rx_byte[0];
                led_green <= rx_byte[1];
                led_blue  <= rx_byte[2];
                state     <= idle;
              end else begin
                mem_go <= 1'b1;       // peek or poke
                state  <= mem_wait;
              end
            end
          end
          mem_wait: if (mem.req && mem.ack) begin
            if (cmd == trs_io_pkg::CMD_BRAM_PEEK) begin
              tx_byte <= mem.rdata;
              tx_load <= 1'b1;
              state   <= respond;
            end else begin
              state <= idle;
            end
          end
          respond: if (rx_valid) state <= idle;  // filler byte from the esp
          default: state <= idle;
        endcase
      end
    end
  end

  // parameter bytes and request payload
  always_ff @(posedge clk) begin
    if (state == read_params && rx_valid)
      params[idx] <= rx_byte;
    if (mem_go) begin
      mem.addr  <= param_addr[MEM_ADDR_W-1:0];  // upper bits dropped
      mem.we    <= (cmd == trs_io_pkg::CMD_BRAM_POKE);
      mem.wdata <= params[2];
    end
  end

endmodule

// File: design/trs_bus_port.sv
`timescale 1ns/1ps

module trs_bus_port #(
  parameter int MEM_ADDR_W = 15
) (
  input  logic                  clk,
  input  logic                  cass_out_sel_n,
  input  trs_io_pkg::trs_addr_t trs_addr,
  input  logic                  trs_rd_n,
  input  logic                  trs_wr_n,
  input  trs_io_pkg::byte_t     trs_din,
  output trs_io_pkg::byte_t     trs_dout,
  output logic                  trs_wait,
  mem_req_if.requester          mem
);

  logic [1:0] rd_sync;   // 2 flop synchronizers
  logic [1:0] wr_sync;
  logic       rd_q;      // last synced level
  logic       wr_q;
  logic       rd_fall;
  logic       wr_fall;
  logic       start;     // new access into the upper 32k

  assign rd_fall = rd_q & ~rd_sync[1];
  assign wr_fall = wr_q & ~wr_sync[1];
  assign start   = (rd_fall | wr_fall) & trs_addr[15] & ~trs_wait & ~mem.ack;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      rd_sync  <= 2'b11;
      wr_sync  <= 2'b11;
      rd_q     <= 1'b1;
      wr_q     <= 1'b1;
      trs_wait <= 1'b0;
      mem.req  <= 1'b0;
    end else begin
      rd_sync <= {rd_sync[0], trs_rd_n};
      wr_sync <= {wr_sync[0], trs_wr_n};
      rd_q    <= rd_sync[1];
      wr_q    <= wr_sync[1];
      if (start) begin
        trs_wait <= 1'b1;       // stall the z80
        mem.req  <= 1'b1;
      end else if (mem.req && mem.ack) begin
        trs_wait <= 1'b0;
        mem.req  <= 1'b0;
      end
    end
  end

  // address and data held steady by the z80 while waiting
  always_ff @(posedge clk) begin
    if (start) begin
      mem.addr  <= trs_addr[MEM_ADDR_W-1:0];
      mem.we    <= wr_fall;       // write wins a double strobe
      mem.wdata <= trs_din;
    end
    if (mem.req && mem.ack && !mem.we)
      trs_dout <= mem.rdata;      // ready before wait drops
  end

endmodule

// File: design/ram_arbiter.sv
`timescale 1ns/1ps

module ram_arbiter #(
  parameter int MEM_ADDR_W = 15
) (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  mem_req_if.arbiter bus,
  mem_req_if.arbiter cmd
);

  typedef enum logic [1:0] {arb_idle, arb_access, arb_ack, arb_release} arb_state_e;

  arb_state_e            state;
  logic                  sel_bus;   // 1 = z80 side owns the grant
  logic                  g_req;
  logic                  g_we;
  logic [MEM_ADDR_W-1:0] g_addr;
  trs_io_pkg::byte_t     g_wdata;
  trs_io_pkg::byte_t     rd_q;      // registered ram output
  trs_io_pkg::byte_t     ram [0:(1 << MEM_ADDR_W)-1];

  assign g_req     = sel_bus ? bus.req   : cmd.req;
  assign g_we      = sel_bus ? bus.we    : cmd.we;
  assign g_addr    = sel_bus ? bus.addr  : cmd.addr;
  assign g_wdata   = sel_bus ? bus.wdata : cmd.wdata;
  assign bus.rdata = rd_q;
  assign cmd.rdata = rd_q;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state   <= arb_idle;
      sel_bus <= 1'b0;
      bus.ack <= 1'b0;
      cmd.ack <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (bus.req) begin        // z80 timing first
            sel_bus <= 1'b1;
            state   <= arb_access;
          end else if (cmd.req) begin
            sel_bus <= 1'b0;
            state   <= arb_access;
          end
        end
        arb_access: state <= arb_ack;  // ram cycle happens here
        arb_ack: begin
          bus.ack <= sel_bus;
          cmd.ack <= ~sel_bus;
          state   <= arb_release;
        end
        arb_release: if (!g_req) begin
          bus.ack <= 1'b0;
          cmd.ack <= 1'b0;
          state   <= arb_idle;
        end
        default: state <= arb_idle;
      endcase
    end
  end

  // one read or write per grant, read first
  always_ff @(posedge clk) begin
    if (state == arb_access) begin
      if (g_we)
        ram[g_addr] <= g_wdata;
      rd_q <= ram[g_addr];
    end
  end

endmodule

// File: design/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top #(
  parameter int MEM_ADDR_W = 15
) (
  input  logic                  clk,
  input  logic                  cass_out_sel_n,
  input  logic                  spi_cs_n,
  input  logic                  spi_sck,
  input  logic                  spi_mosi,
  output logic                  spi_miso,
  input  trs_io_pkg::trs_addr_t trs_addr,
  input  logic                  trs_rd_n,
  input  logic                  trs_wr_n,
  input  trs_io_pkg::byte_t     trs_din,
  output trs_io_pkg::byte_t     trs_dout,
  output logic                  trs_wait,
  output logic                  led_red,
  output logic                  led_green,
  output logic                  led_blue,
  output logic                  spi_error
);

  trs_io_pkg::byte_t rx_byte;
  trs_io_pkg::byte_t tx_byte;
  logic              rx_valid;
  logic              tx_load;
  logic              frame_active;

  mem_req_if #(.MEM_ADDR_W(MEM_ADDR_W)) cmd_mem ();  // esp side
  mem_req_if #(.MEM_ADDR_W(MEM_ADDR_W)) bus_mem ();  // z80 side

  spi_slave u_spi (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_mosi       (spi_mosi),
    .tx_byte        (tx_byte),
    .tx_load        (tx_load),
    .spi_miso       (spi_miso),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .frame_active   (frame_active)
  );

  cmd_engine #(.MEM_ADDR_W(MEM_ADDR_W)) u_cmd (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .frame_active   (frame_active),
    .tx_byte        (tx_byte),
    .tx_load        (tx_load),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .spi_error      (spi_error),
    .mem            (cmd_mem.requester)
  );

  trs_bus_port #(.MEM_ADDR_W(MEM_ADDR_W)) u_bus (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .trs_addr       (trs_addr),
    .trs_rd_n       (trs_rd_n),
    .trs_wr_n       (trs_wr_n),
    .trs_din        (trs_din),
    .trs_dout       (trs_dout),
    .trs_wait       (trs_wait),
    .mem            (bus_mem.requester)
  );

  ram_arbiter #(.MEM_ADDR_W(MEM_ADDR_W)) u_arb (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .bus            (bus_mem.arbiter),
    .cmd            (cmd_mem.arbiter)
  );

endmodule

// File: tb/trs_io_sva.sv
`timescale 1ns/1ps

// four-phase rules on both arbiter ports
module trs_io_sva (
  input logic clk,
  input logic cass_out_sel_n,
  input logic bus_req,
  input logic bus_ack,
  input logic cmd_req,
  input logic cmd_ack
);

  // ack only answers a live request
  bus_ack_on_req: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $rose(bus_ack) |-> bus_req) else $error("bus ack rose without req");
  cmd_ack_on_req: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    $rose(cmd_ack) |-> cmd_req) else $error("cmd ack rose without req");

  // no request withdrawn early
  bus_req_held: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    (bus_req && !bus_ack) |=> bus_req) else $error("bus req dropped before ack");
  cmd_req_held: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    (cmd_req && !cmd_ack) |=> cmd_req) else $error("cmd req dropped before ack");

  // one grant at a time
  one_ack: assert property (@(posedge clk) disable iff (!cass_out_sel_n)
    !(bus_ack && cmd_ack)) else $error("bus and cmd ack high together");

endmodule

bind ram_arbiter trs_io_sva u_sva (
  .clk            (clk),
  .cass_out_sel_n (cass_out_sel_n),
  .bus_req        (bus.req),
  .bus_ack        (bus.ack),
  .cmd_req        (cmd.req),
  .cmd_ack        (cmd.ack)
);

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int HALF_SCK  = 6;                    // clk per sck phase
  localparam int BYTE_CLKS = 16 * HALF_SCK + 32;   // 8 bits plus the gap
  localparam int XFER_CLKS = 15;                   // cs setup and release
  localparam int TRS_CLKS  = 24;                   // one stretched z80 cycle
  localparam int N_BYTES   = 197;                  // spi bytes over all tests
  localparam int N_XFERS   = 52;                   // cs low periods
  localparam int N_TRS     = 4;
  localparam int LIMIT     = 4 * (9 + N_BYTES * BYTE_CLKS + N_XFERS * XFER_CLKS
                                  + N_TRS * TRS_CLKS);
  // strobe lands near the eighth sck rise of the poke data byte
  localparam int CLASH_DLY = 8 + 3 * BYTE_CLKS + 15 * HALF_SCK;

  logic                  clk = 1'b0;
  logic                  cass_out_sel_n;
  logic                  spi_cs_n;
  logic                  spi_sck;
  logic                  spi_mosi;
  logic                  spi_miso;
  trs_io_pkg::trs_addr_t trs_addr;
  logic                  trs_rd_n;
  logic                  trs_wr_n;
  trs_io_pkg::byte_t     trs_din;
  trs_io_pkg::byte_t     trs_dout;
  logic                  trs_wait;
  logic                  led_red;
  logic                  led_green;
  logic                  led_blue;
  logic                  spi_error;

  trs_io_pkg::byte_t shadow [0:32767];  // mirror of the dut ram
  string             name_q [$];        // compares waiting for the checker
  logic [15:0]       got_q [$];
  logic [15:0]       exp_q [$];
  int                seed = 32'h2dd5_871b;
  int                cycles = 0;

  always #4 clk = ~clk;  // 8 ns

  trs_io_top #(.MEM_ADDR_W(15)) u_dut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_cs_n       (spi_cs_n),
    .spi_sck        (spi_sck),
    .spi_mosi       (spi_mosi),
    .spi_miso       (spi_miso),
    .trs_addr       (trs_addr),
    .trs_rd_n       (trs_rd_n),
    .trs_wr_n       (trs_wr_n),
    .trs_din        (trs_din),
    .trs_dout       (trs_dout),
    .trs_wait       (trs_wait),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .spi_error      (spi_error)
  );

  // expected reply byte for an opcode
  function automatic trs_io_pkg::byte_t ref_resp(input logic [7:0] op, input logic [14:0] addr);
    case (op)
      8'd0:    ref_resp = 8'haf;          // cookie
      8'd15:   ref_resp = {3'd0, 5'd3};   // major 0, minor 3
      8'd2:    ref_resp = shadow[addr];   // peek sees the mirror
      default: ref_resp = 8'h00;          // no reply, zeros shift out
    endcase
  endfunction

  task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic expect_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  // compare process, empties the queue every clock
  always @(posedge clk) begin
    while (got_q.size() > 0)
      check(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the tests did not finish within %0d clk cycles", LIMIT);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic cs_low();
    @(negedge clk);
    spi_cs_n = 1'b0;
    repeat (6) @(negedge clk);  // cs through the synchronizer
  endtask

  task automatic cs_high();
    spi_cs_n = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  // one mode 0 byte, msb first
  task automatic spi_xfer(input trs_io_pkg::byte_t tx, output trs_io_pkg::byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = tx[i];
      repeat (HALF_SCK) @(negedge clk);
      spi_sck = 1'b1;
      rx[i]   = spi_miso;           // settled since the last fall
      repeat (HALF_SCK) @(negedge clk);
      spi_sck = 1'b0;
    end
    spi_mosi = 1'b0;
    repeat (32) @(negedge clk);     // room for one bus access ahead
  endtask

  // opcode then filler, reply comes back on the filler
  task automatic spi_cmd(input logic [7:0] op, output trs_io_pkg::byte_t resp);
    trs_io_pkg::byte_t dummy;
    cs_low();
    spi_xfer(op, dummy);
    spi_xfer(8'h00, resp);
    cs_high();
  endtask

  task automatic poke(input logic [14:0] addr, input trs_io_pkg::byte_t data);
    trs_io_pkg::byte_t dummy;
    cs_low();
    spi_xfer(trs_io_pkg::CMD_BRAM_POKE, dummy);
    spi_xfer(addr[7:0], dummy);
    spi_xfer({1'b0, addr[14:8]}, dummy);
    spi_xfer(data, dummy);
    cs_high();
    shadow[addr] = data;
  endtask

  task automatic peek_check(input logic [14:0] addr);
    trs_io_pkg::byte_t dummy;
    trs_io_pkg::byte_t resp;
    cs_low();
    spi_xfer(trs_io_pkg::CMD_BRAM_PEEK, dummy);
    spi_xfer(addr[7:0], dummy);
    spi_xfer({1'b0, addr[14:8]}, dummy);
    spi_xfer(8'h00, resp);          // filler
    cs_high();
    expect_val($sformatf("spi_miso (peek 0x%0h)", addr), 16'(resp),
               16'(ref_resp(trs_io_pkg::CMD_BRAM_PEEK, addr)));
  endtask

  task automatic set_led(input trs_io_pkg::byte_t val);
    trs_io_pkg::byte_t dummy;
    cs_low();
    spi_xfer(trs_io_pkg::CMD_SET_LED, dummy);
    spi_xfer(val, dummy);
    cs_high();
  endtask

  // z80 memory cycle, held until trs_wait is low
  task automatic trs_access(input logic wr, input trs_io_pkg::trs_addr_t addr,
                            input trs_io_pkg::byte_t din, output trs_io_pkg::byte_t dout,
                            output logic stalled);
    stalled  = 1'b0;
    @(negedge clk);
    trs_addr = addr;
    trs_din  = din;
    if (wr)
      trs_wr_n = 1'b0;
    else
      trs_rd_n = 1'b0;
    repeat (4) begin                // strobe through the sync flops
      @(negedge clk);
      stalled = stalled | trs_wait;
    end
    while (trs_wait)
      @(negedge clk);               // bounded by the cycle limit
    dout     = trs_dout;
    trs_rd_n = 1'b1;
    trs_wr_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  initial begin
    trs_io_pkg::byte_t resp;
    trs_io_pkg::byte_t rd;
    trs_io_pkg::byte_t val;
    logic [14:0]       a;
    logic [14:0]       b;
    logic [31:0]       r;
    logic              stalled;

    cass_out_sel_n = 1'b0;
    spi_cs_n       = 1'b1;
    spi_sck        = 1'b0;
    spi_mosi       = 1'b0;
    trs_addr       = '0;
    trs_rd_n       = 1'b1;
    trs_wr_n       = 1'b1;
    trs_din        = '0;
    repeat (5) @(negedge clk);
    cass_out_sel_n = 1'b1;
    repeat (4) @(negedge clk);

    // quiet outputs out of reset
    expect_val("led_red", 16'(led_red), 16'h0);
    expect_val("led_green", 16'(led_green), 16'h0);
    expect_val("led_blue", 16'(led_blue), 16'h0);
    expect_val("trs_wait", 16'(trs_wait), 16'h0);
    expect_val("spi_error", 16'(spi_error), 16'h0);
    expect_val("spi_miso", 16'(spi_miso), 16'h0);
    spi_cmd(trs_io_pkg::CMD_GET_COOKIE, resp);
    expect_val("spi_miso (cookie)", 16'(resp), 16'(ref_resp(8'd0, 15'd0)));
    spi_cmd(trs_io_pkg::CMD_GET_VERSION, resp);
    expect_val("spi_miso (version)", 16'(resp), 16'(ref_resp(8'd15, 15'd0)));

    // random poke then peek
    for (int n = 0; n < 20; n++) begin
      r   = $random(seed);
      a   = r[14:0];
      val = r[22:15];
      poke(a, val);
      peek_check(a);
    end

    // z80 write seen by peek
    r   = $random(seed);
    a   = r[14:0];
    val = r[22:15];
    trs_access(1'b1, {1'b1, a}, val, rd, stalled);
    shadow[a] = val;
    expect_val("trs_wait (upper write)", 16'(stalled), 16'h1);
    peek_check(a);
    // poke seen by a z80 read
    r   = $random(seed);
    b   = r[14:0];
    val = r[22:15];
    poke(b, val);
    trs_access(1'b0, {1'b1, b}, 8'h00, rd, stalled);
    expect_val("trs_dout", 16'(rd), 16'(shadow[b]));
    // lower 32k is outside the window
    trs_access(1'b1, {1'b0, a}, ~shadow[a], rd, stalled);
    expect_val("trs_wait (lower write)", 16'(stalled), 16'h0);
    peek_check(a);

    r   = $random(seed);
    val = r[7:0];
    set_led(val);
    expect_val("led_red", 16'(led_red), 16'(val[0]));
    expect_val("led_green", 16'(led_green), 16'(val[1]));
    expect_val("led_blue", 16'(led_blue), 16'(val[2]));

    // z80 write while a poke is in flight
    r   = $random(seed);
    a   = r[14:0];
    val = r[22:15];
    b   = a ^ 15'h4000;
    fork
      poke(a, val);
      begin
        repeat (CLASH_DLY) @(negedge clk);
        trs_access(1'b1, {1'b1, b}, ~val, rd, stalled);
      end
    join
    shadow[b] = ~val;
    peek_check(a);
    peek_check(b);
    expect_val("spi_error", 16'(spi_error), 16'h0);

    // bad opcode, error sticks
    cs_low();
    spi_xfer(8'h40, resp);
    cs_high();
    expect_val("spi_error", 16'(spi_error), 16'h1);
    spi_cmd(trs_io_pkg::CMD_GET_VERSION, resp);
    expect_val("spi_miso (version)", 16'(resp), 16'(ref_resp(8'd15, 15'd0)));
    peek_check(a);
    expect_val("spi_error", 16'(spi_error), 16'h1);

    repeat (4) @(negedge clk);      // checker drains
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: compile.f
design/trs_io_pkg.sv
design/mem_req_if.sv
design/spi_slave.sv
design/cmd_engine.sv
design/trs_bus_port.sv
design/ram_arbiter.sv
design/trs_io_top.sv
tb/trs_io_sva.sv
tb/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
